//--- stepper_controller.f
rtl/motion_pkg.sv
rtl/spi_word.sv
rtl/command_decoder.sv
rtl/step_generator.sv
rtl/dual_hbridge.sv
rtl/quad_encoder.sv
rtl/stepper_controller.sv
test/stepper_controller_assert.sv
test/stepper_controller_checker.sv
test/stepper_controller_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= stepper_controller_tb
FILELIST  ?= stepper_controller.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- test/stepper_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_controller_tb
  import motion_pkg::*;
;

  localparam int N_MAX       = 16;
  localparam int WORD_CYCLES = 64 * 8 + 40;
  // Long move, 400 ticks at the default divisor
  localparam int MOVE_CYCLES = 400 * 40 + 100;

  logic CLK;
  logic reset;
  logic SCK;
  logic CS;
  logic COPI;
  logic ENC_A;
  logic ENC_B;
  wire  CIPO;
  wire  LED;
  wire  M_PHASE_A1;
  wire  M_PHASE_A2;
  wire  M_PHASE_B1;
  wire  M_PHASE_B2;
  wire  ENC_FAULT;

  // Command table, one row per entry
  int    n_entries;
  int    tbl_nw     [N_MAX];
  word_t tbl_w      [N_MAX][4];
  // Word whose captured reply is checked, -1 for none
  int    tbl_chk    [N_MAX];
  // 0 literal reply, 1 encoder model
  int    tbl_mode   [N_MAX];
  word_t tbl_exp    [N_MAX];
  bit    tbl_spin   [N_MAX];
  bit    tbl_settle [N_MAX];
  bit    tbl_drop   [N_MAX];

  // Reference model state
  logic [31:0] rng_state;
  count_t      model_acc;
  count_t      enc_model;
  int          enc_pos;
  bit          model_en;
  bit          model_half;
  bit          pend_dir;
  int          pending;
  int          steps;
  int          e;
  int          i;
  header_t     hdr;

  stepper_controller dut (
    .CLK(CLK), .reset(reset), .SCK(SCK), .CS(CS), .COPI(COPI), .ENC_A(ENC_A),
    .ENC_B(ENC_B), .CIPO(CIPO), .LED(LED), .M_PHASE_A1(M_PHASE_A1),
    .M_PHASE_A2(M_PHASE_A2), .M_PHASE_B1(M_PHASE_B1), .M_PHASE_B2(M_PHASE_B2),
    .ENC_FAULT(ENC_FAULT)
  );

  stepper_controller_checker chk (
    .CLK(CLK), .reset(reset), .SCK(SCK), .CS(CS), .CIPO(CIPO), .led(LED),
    .phase_a1(M_PHASE_A1), .phase_a2(M_PHASE_A2), .phase_b1(M_PHASE_B1),
    .phase_b2(M_PHASE_B2), .fault(ENC_FAULT)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t header_word(input header_t cmd, input int low);
    return {cmd, 56'(low)};
  endfunction

  task automatic add_entry(input int nw, input word_t w0, input word_t w1, input word_t w2,
                           input word_t w3, input int chk_idx, input int mode,
                           input word_t exp, input bit spin, input bit settle, input bit drop);
    tbl_nw[n_entries]     = nw;
    tbl_w[n_entries][0]   = w0;
    tbl_w[n_entries][1]   = w1;
    tbl_w[n_entries][2]   = w2;
    tbl_w[n_entries][3]   = w3;
    tbl_chk[n_entries]    = chk_idx;
    tbl_mode[n_entries]   = mode;
    tbl_exp[n_entries]    = exp;
    tbl_spin[n_entries]   = spin;
    tbl_settle[n_entries] = settle;
    tbl_drop[n_entries]   = drop;
    n_entries = n_entries + 1;
  endtask

  // Second-order DDA, accumulator carried across moves
  task automatic run_dda(input count_t dur, input count_t inc0, input count_t accel,
                         output int n);
    count_t inc;
    count_t t;
    n = 0;
    inc = inc0;
    for (t = 1; t <= dur; t++) begin
      inc = (t == 1) ? inc0 : inc + accel;
      model_acc = model_acc + inc;
      if (model_acc > 0) begin
        n = n + 1;
        model_acc = model_acc - STEP_THRESHOLD;
      end
    end
  endtask

  // Mode 0 host, 4 CLK cycles per SCK half period
  task automatic send_word(input word_t w);
    logic led_before;
    int   b;
    led_before = LED;
    @(posedge CLK);
    CS <= 1'b0;
    repeat (4) @(posedge CLK);
    for (b = 63; b >= 0; b--) begin
      COPI <= w[b];
      repeat (4) @(posedge CLK);
      SCK <= 1'b1;
      repeat (4) @(posedge CLK);
      SCK <= 1'b0;
    end
    // LED toggle marks word_valid
    while (LED == led_before) @(posedge CLK);
    repeat (8) @(posedge CLK);
    CS <= 1'b1;
    repeat (8) @(posedge CLK);
  endtask

  // Gray order (a,b) 00, 10, 11, 01 counts up
  task automatic move_encoder(input bit up);
    enc_pos = up ? (enc_pos + 1) % 4 : (enc_pos + 3) % 4;
    @(posedge CLK);
    ENC_A <= (enc_pos == 1) || (enc_pos == 2);
    ENC_B <= (enc_pos == 2) || (enc_pos == 3);
    repeat (4) @(posedge CLK);
  endtask

  task automatic spin_encoder();
    int fwd;
    int back;
    int k;
    rng_state = xorshift(rng_state);
    fwd = int'(rng_state % 24) + 1;
    rng_state = xorshift(rng_state);
    back = int'(rng_state % 24);
    for (k = 0; k < fwd; k++) move_encoder(1'b1);
    for (k = 0; k < back; k++) move_encoder(1'b0);
    enc_model = enc_model + fwd - back;
    repeat (6) @(posedge CLK);
  endtask

  task automatic fill_table();
    word_t nop;
    word_t ver;
    nop = '0;
    ver = {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
    n_entries = 0;
    add_entry(2, header_word(CMD_API_VERSION, 0), nop, nop, nop, 1, 0, ver, 0, 0, 0);
    add_entry(2, nop, nop, nop, nop, 1, 1, '0, 1, 0, 0);
    // Move while the bridges are off
    add_entry(4, header_word(CMD_COORDINATED_STEP, 1), 64'd20, 64'h2000_0000_0000_0000,
              64'h0100_0000_0000_0000, 1, 0, 64'd4, 0, 1, 0);
    add_entry(1, header_word(CMD_MOTOR_ENABLE, 1), nop, nop, nop, -1, 0, '0, 0, 0, 0);
    add_entry(1, header_word(CMD_MICROSTEPS, 1), nop, nop, nop, -1, 0, '0, 0, 0, 0);
    add_entry(4, header_word(CMD_COORDINATED_STEP, 1), 64'd20, 64'h2000_0000_0000_0000,
              64'h0100_0000_0000_0000, 1, 0, 64'd4, 0, 1, 0);
    add_entry(4, header_word(CMD_COORDINATED_STEP, 0), 64'd20, 64'h2000_0000_0000_0000,
              64'h0100_0000_0000_0000, 1, 0, 64'd4, 0, 1, 0);
    add_entry(1, header_word(CMD_MICROSTEPS, 0), nop, nop, nop, -1, 0, '0, 0, 0, 0);
    add_entry(4, header_word(CMD_COORDINATED_STEP, 1), 64'd24, 64'h1800_0000_0000_0000,
              64'h0200_0000_0000_0000, 1, 0, 64'd4, 0, 1, 0);
    add_entry(2, nop, nop, nop, nop, 1, 1, '0, 1, 0, 0);
    // Five long moves back to back, fifth finds the queue full
    for (int m = 0; m < 5; m++) begin
      add_entry(4, header_word(CMD_COORDINATED_STEP, 1), 64'd400, 64'h0400_0000_0000_0000,
                64'd0, 1, 0, word_t'(4 - m), 0, (m == 4), (m == 4));
    end
  endtask

  // Watchdog sized from the table length
  initial begin
    repeat (N_MAX * (4 * WORD_CYCLES + 4 * MOVE_CYCLES) + 2000) @(posedge CLK);
    $display("Timeout: the test sequence did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    SCK        = 1'b0;
    CS         = 1'b1;
    COPI       = 1'b0;
    ENC_A      = 1'b0;
    ENC_B      = 1'b0;
    rng_state  = 32'd74621;
    model_acc  = '0;
    enc_model  = '0;
    enc_pos    = 0;
    model_en   = 1'b0;
    model_half = 1'b0;
    pend_dir   = 1'b0;
    pending    = 0;
    fill_table();
    repeat (4) @(posedge CLK);
    reset <= 1'b0;
    repeat (4) @(posedge CLK);

    for (e = 0; e < n_entries; e++) begin
      if (tbl_spin[e]) spin_encoder();
      for (i = 0; i < tbl_nw[e]; i++) begin
        send_word(tbl_w[e][i]);
        if (i == tbl_chk[e]) begin
          chk.check_reply((tbl_mode[e] == 1) ? word_t'(enc_model) : tbl_exp[e]);
        end
      end
      // Track configuration and predicted steps
      hdr = tbl_w[e][0][63:56];
      if (hdr == CMD_MOTOR_ENABLE) model_en = tbl_w[e][0][0];
      if (hdr == CMD_MICROSTEPS) model_half = tbl_w[e][0][0];
      if ((hdr == CMD_COORDINATED_STEP) && !tbl_drop[e]) begin
        run_dda(count_t'(tbl_w[e][1]), count_t'(tbl_w[e][2]), count_t'(tbl_w[e][3]), steps);
        pending  = pending + (model_en ? steps : 0);
        pend_dir = tbl_w[e][0][0];
      end
      if (tbl_settle[e]) begin
        // Queue drained, then let the bridge outputs settle
        while (dut.u_step_generator.slots_free != slot_t'(MOVE_DEPTH)) @(posedge CLK);
        repeat (6) @(posedge CLK);
        chk.check_steps(pending, pend_dir, model_half);
        if (!model_en) chk.check_phases_off();
        chk.clear_counts();
        pending = 0;
      end
    end

    // Both encoder pins at once
    @(posedge CLK);
    ENC_A <= ~ENC_A;
    ENC_B <= ~ENC_B;
    repeat (6) @(posedge CLK);
    chk.check_fault(1'b1);
    repeat (20) @(posedge CLK);
    chk.check_fault(1'b1);
    @(posedge CLK);
    reset <= 1'b1;
    ENC_A <= 1'b0;
    ENC_B <= 1'b0;
    repeat (4) @(posedge CLK);
    reset <= 1'b0;
    repeat (6) @(posedge CLK);
    chk.check_fault(1'b0);

    chk.report(dut.u_step_generator.u_assert.failures);
    if ((chk.errors == 0) && (dut.u_step_generator.u_assert.failures == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/stepper_controller_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_controller_checker
  import motion_pkg::*;
(
  input wire CLK,
  input wire reset,
  input wire SCK,
  input wire CS,
  input wire CIPO,
  input wire led,
  input wire phase_a1,
  input wire phase_a2,
  input wire phase_b1,
  input wire phase_b2,
  input wire fault
);

  // Reply capture from the SPI pins
  logic  sck_prev;
  logic  cs_prev;
  word_t shift;
  word_t last_reply;
  int    nbits;
  // LED level expected after the words seen so far
  bit    led_exp;
  // Phase advances by stride and direction
  int    prev_idx;
  int    up1;
  int    up2;
  int    dn1;
  int    dn2;
  int    bad_jumps;
  int    checks;
  int    errors;

  initial begin
    cs_prev   = 1'b1;
    nbits     = 0;
    led_exp   = 1'b0;
    prev_idx  = -1;
    up1       = 0;
    up2       = 0;
    dn1       = 0;
    dn2       = 0;
    bad_jumps = 0;
    checks    = 0;
    errors    = 0;
  end

  // Coil pattern back to its table index, -1 when off
  function automatic int coil_index(input logic [3:0] c);
    case (c)
      4'b1000: return 0;
      4'b1010: return 1;
      4'b0010: return 2;
      4'b0110: return 3;
      4'b0100: return 4;
      4'b0101: return 5;
      4'b0001: return 6;
      4'b1001: return 7;
      default: return -1;
    endcase
  endfunction

  always @(posedge CLK) begin : watch
    int idx;
    int delta;
    sck_prev <= SCK;
    cs_prev  <= CS;
    // Host samples CIPO on SCK rising edges
    if (CS) begin
      nbits <= 0;
    end else if (SCK && !sck_prev) begin
      shift <= {shift[62:0], CIPO};
      if (nbits == 63) begin
        last_reply <= {shift[62:0], CIPO};
        nbits      <= 0;
        // Each complete word flips the activity LED
        led_exp = ~led_exp;
      end else begin
        nbits <= nbits + 1;
      end
    end
    if (reset) begin
      led_exp = 1'b0;
    end else if (CS && !cs_prev) begin
      // LED has long settled when the host deselects
      compare_int("LED", led, led_exp);
    end
    idx = coil_index({phase_a1, phase_a2, phase_b1, phase_b2});
    if (reset) begin
      prev_idx = -1;
    end else if (idx >= 0) begin
      if ((prev_idx >= 0) && (idx != prev_idx)) begin
        delta = (idx - prev_idx + 8) % 8;
        case (delta)
          1: up1 = up1 + 1;
          2: up2 = up2 + 1;
          6: dn2 = dn2 + 1;
          7: dn1 = dn1 + 1;
          default: bad_jumps = bad_jumps + 1;
        endcase
      end
      prev_idx = idx;
    end
  end

  task automatic compare_int(input string name, input longint got, input longint exp);
    checks = checks + 1;
    if (got != exp) begin
      errors = errors + 1;
      $display("Fail %0t %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic check_reply(input word_t exp);
    @(negedge CLK);
    checks = checks + 1;
    if (last_reply !== exp) begin
      errors = errors + 1;
      $display("Fail %0t reply_word expected %h got %h", $time, exp, last_reply);
    end
  endtask

  // Expected count lands in one stride and direction bin only
  task automatic check_steps(input int exp, input bit dir, input bit half);
    @(negedge CLK);
    compare_int("phase_up_half", up1, (dir && half) ? exp : 0);
    compare_int("phase_up_full", up2, (dir && !half) ? exp : 0);
    compare_int("phase_down_half", dn1, (!dir && half) ? exp : 0);
    compare_int("phase_down_full", dn2, (!dir && !half) ? exp : 0);
    compare_int("phase_bad_jump", bad_jumps, 0);
  endtask

  task automatic check_phases_off();
    @(negedge CLK);
    compare_int("phases", {phase_a1, phase_a2, phase_b1, phase_b2}, 0);
  endtask

  task automatic check_fault(input bit exp);
    @(negedge CLK);
    compare_int("ENC_FAULT", fault, exp);
  endtask

  task automatic clear_counts();
    up1       = 0;
    up2       = 0;
    dn1       = 0;
    dn2       = 0;
    bad_jumps = 0;
  endtask

  task automatic report(input int assert_failures);
    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
             assert_failures);
  endtask

endmodule

`default_nettype wire

//--- test/stepper_controller_assert.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_controller_assert
  import motion_pkg::*;
(
  input wire        CLK,
  input wire        reset,
  input wire        step,
  input wire slot_t slots_free,
  input wire        move_push
);

  // Count of failed assertions
  int failures;

  initial begin
    failures = 0;
  end

  // Step pulse is a single cycle wide
  step_one_cycle: assert property (@(posedge CLK) disable iff (reset) step |=> !step)
    else begin
      failures = failures + 1;
      $error("step held for more than one cycle");
    end

  // Free count never above the ring size
  slots_in_range: assert property (@(posedge CLK) disable iff (reset)
    slots_free <= slot_t'(MOVE_DEPTH))
    else begin
      failures = failures + 1;
      $error("slots_free above MOVE_DEPTH");
    end

  // Decoder only pushes into a queue with room
  push_has_room: assert property (@(posedge CLK) disable iff (reset)
    move_push |-> (slots_free != '0))
    else begin
      failures = failures + 1;
      $error("move_push with a full queue");
    end

endmodule

// Generator sees the push, the free count and the step pulse
bind step_generator stepper_controller_assert u_assert (
  .CLK(CLK), .reset(reset), .step(step), .slots_free(slots_free), .move_push(move_push)
);

`default_nettype wire

//--- rtl/stepper_controller.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_controller
  import motion_pkg::*;
(
  input  wire  CLK,
  input  wire  reset,
  input  wire  SCK,
  input  wire  CS,
  input  wire  COPI,
  input  wire  ENC_A,
  input  wire  ENC_B,
  output wire  CIPO,
  output logic LED,
  output wire  M_PHASE_A1,
  output wire  M_PHASE_A2,
  output wire  M_PHASE_B1,
  output wire  M_PHASE_B2,
  output wire  ENC_FAULT
);

  // Host link
  word_t    rx_word;
  word_t    reply_word;
  logic     word_valid;
  count_t   enc_count;
  // Configuration and moves
  logic     enable;
  logic     half_step;
  divisor_t divisor;
  logic     move_push;
  logic     move_dir;
  count_t   move_duration;
  count_t   move_increment;
  count_t   move_accel;
  slot_t    slots_free;
  // Step output
  logic     step;
  logic     dir;

  spi_word u_spi_word (
    .CLK(CLK), .reset(reset), .SCK(SCK), .CS(CS), .COPI(COPI),
    .tx_word(reply_word), .CIPO(CIPO), .word_valid(word_valid), .rx_word(rx_word)
  );

  command_decoder u_command_decoder (
    .CLK(CLK), .reset(reset), .word_valid(word_valid), .rx_word(rx_word),
    .enc_count(enc_count), .slots_free(slots_free), .reply_word(reply_word),
    .enable(enable), .half_step(half_step), .divisor(divisor),
    .move_push(move_push), .move_dir(move_dir), .move_duration(move_duration),
    .move_increment(move_increment), .move_accel(move_accel)
  );

  step_generator u_step_generator (
    .CLK(CLK), .reset(reset), .move_push(move_push), .move_dir(move_dir),
    .move_duration(move_duration), .move_increment(move_increment),
    .move_accel(move_accel), .divisor(divisor), .slots_free(slots_free),
    .step(step), .dir(dir)
  );

  dual_hbridge u_dual_hbridge (
    .CLK(CLK), .reset(reset), .step(step), .dir(dir), .enable(enable),
    .half_step(half_step), .phase_a1(M_PHASE_A1), .phase_a2(M_PHASE_A2),
    .phase_b1(M_PHASE_B1), .phase_b2(M_PHASE_B2)
  );

  quad_encoder u_quad_encoder (
    .CLK(CLK), .reset(reset), .enc_a(ENC_A), .enc_b(ENC_B),
    .count(enc_count), .fault(ENC_FAULT)
  );

  // Activity LED flips once per received word
  always_ff @(posedge CLK) begin
    if (reset) begin
      LED <= 1'b0;
    end else if (word_valid) begin
      LED <= ~LED;
    end
  end

endmodule

`default_nettype wire

//--- rtl/quad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module quad_encoder
  import motion_pkg::*;
(
  input  wire    CLK,
  input  wire    reset,
  input  wire    enc_a,
  input  wire    enc_b,
  output count_t count,
  output logic   fault
);

  // Stage 0 is the newest sample
  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_change;
  logic       b_change;
  logic       up;

  assign a_change = a_sync[0] ^ a_sync[1];
  assign b_change = b_sync[0] ^ b_sync[1];
  // A leading B counts up
  assign up       = a_sync[0] ^ b_sync[1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_sync <= 2'b00;
      b_sync <= 2'b00;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[0], enc_a};
      b_sync <= {b_sync[0], enc_b};
      // Both pins at once is not Gray code, latch until reset
      if (a_change && b_change) begin
        fault <= 1'b1;
      end else if (a_change || b_change) begin
        count <= up ? count + 64'sd1 : count - 64'sd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dual_hbridge.sv
`timescale 1ns/1ps
`default_nettype none

module dual_hbridge
  import motion_pkg::*;
(
  input  wire  CLK,
  input  wire  reset,
  input  wire  step,
  input  wire  dir,
  input  wire  enable,
  input  wire  half_step,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  phase_t     index;
  phase_t     stride;
  // Coil drive as {a1, a2, b1, b2}
  logic [3:0] coils;

  // Full step skips the two-coil entries
  assign stride = half_step ? phase_t'(1) : phase_t'(2);

  always_ff @(posedge CLK) begin
    if (reset) begin
      index <= '0;
    end else if (step && enable) begin
      index <= dir ? index + stride : index - stride;
    end
  end

  // Half-step table, even entries drive one coil
  always_comb begin
    case (index)
      3'd0:    coils = 4'b1000;
      3'd1:    coils = 4'b1010;
      3'd2:    coils = 4'b0010;
      3'd3:    coils = 4'b0110;
      3'd4:    coils = 4'b0100;
      3'd5:    coils = 4'b0101;
      3'd6:    coils = 4'b0001;
      default: coils = 4'b1001;
    endcase
  end

  // Bridges off while disabled
  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? coils : 4'b0000;

endmodule

`default_nettype wire

//--- rtl/step_generator.sv
`timescale 1ns/1ps
`default_nettype none

module step_generator
  import motion_pkg::*;
(
  input  wire         CLK,
  input  wire         reset,
  input  wire         move_push,
  input  wire         move_dir,
  input  wire count_t move_duration,
  input  wire count_t move_increment,
  input  wire count_t move_accel,
  input  wire divisor_t divisor,
  output slot_t       slots_free,
  output logic        step,
  output logic        dir
);

  // Move ring, head entry stays occupied while it runs
  logic   q_dir       [MOVE_DEPTH];
  count_t q_duration  [MOVE_DEPTH];
  count_t q_increment [MOVE_DEPTH];
  count_t q_accel     [MOVE_DEPTH];
  logic [$clog2(MOVE_DEPTH)-1:0] wr_idx;
  logic [$clog2(MOVE_DEPTH)-1:0] rd_idx;
  slot_t    used;
  logic     push_ok;
  // DDA state
  logic     running;
  logic     first_tick;
  logic     tick;
  logic     finish;
  divisor_t clk_count;
  count_t   ticks_left;
  count_t   inc_q;
  count_t   accum;
  count_t   inc_next;
  count_t   acc_next;

  assign slots_free = slot_t'(MOVE_DEPTH) - used;
  assign push_ok    = move_push && (used != slot_t'(MOVE_DEPTH));
  // One tick every divisor cycles
  assign tick       = running && (clk_count == divisor - 1'b1);
  assign inc_next   = first_tick ? q_increment[rd_idx] : inc_q + q_accel[rd_idx];
  assign acc_next   = accum + inc_next;
  // Zero duration ends at once
  assign finish     = running && ((ticks_left == '0) || (tick && (ticks_left == 64'sd1)));

  always_ff @(posedge CLK) begin
    if (push_ok) begin
      q_dir[wr_idx]       <= move_dir;
      q_duration[wr_idx]  <= move_duration;
      q_increment[wr_idx] <= move_increment;
      q_accel[wr_idx]     <= move_accel;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_idx     <= '0;
      rd_idx     <= '0;
      used       <= '0;
      running    <= 1'b0;
      first_tick <= 1'b0;
      clk_count  <= '0;
      ticks_left <= '0;
      inc_q      <= '0;
      accum      <= '0;
      step       <= 1'b0;
      dir        <= 1'b0;
    end else begin
      step <= 1'b0;
      if (push_ok) begin
        wr_idx <= wr_idx + 1'b1;
      end
      used <= used + slot_t'(push_ok) - slot_t'(finish);
      if (!running) begin
        // Load the head move when one is waiting
        clk_count <= '0;
        if (used != '0) begin
          running    <= 1'b1;
          first_tick <= 1'b1;
          ticks_left <= q_duration[rd_idx];
          dir        <= q_dir[rd_idx];
        end
      end else begin
        clk_count <= tick ? '0 : clk_count + 1'b1;
        if (tick && (ticks_left != '0)) begin
          first_tick <= 1'b0;
          inc_q      <= inc_next;
          ticks_left <= ticks_left - 1'b1;
          // Step on a positive accumulator, carry the rest over
          if (acc_next > 0) begin
            step  <= 1'b1;
            accum <= acc_next - STEP_THRESHOLD;
          end else begin
            accum <= acc_next;
          end
        end
        if (finish) begin
          running <= 1'b0;
          rd_idx  <= rd_idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder
  import motion_pkg::*;
(
  input  wire         CLK,
  input  wire         reset,
  input  wire         word_valid,
  input  wire word_t  rx_word,
  input  wire count_t enc_count,
  input  wire slot_t  slots_free,
  output word_t       reply_word,
  output logic        enable,
  output logic        half_step,
  output divisor_t    divisor,
  output logic        move_push,
  output logic        move_dir,
  output count_t      move_duration,
  output count_t      move_increment,
  output count_t      move_accel
);

  decoder_state_t state;
  header_t        header;
  // Reply select for the next word; neither set means encoder count
  logic           reply_version;
  logic           reply_slots;

  assign header = rx_word[63:56];

  // Count and free slots stay live until the SPI block samples them
  always_comb begin
    if (reply_version) begin
      reply_word = {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
    end else if (reply_slots) begin
      reply_word = word_t'(slots_free);
    end else begin
      reply_word = word_t'(enc_count);
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state         <= IDLE_HEADER;
      enable        <= 1'b0;
      half_step     <= 1'b0;
      divisor       <= DEFAULT_DIVISOR;
      move_push     <= 1'b0;
      reply_version <= 1'b0;
      reply_slots   <= 1'b0;
    end else begin
      move_push <= 1'b0;
      if (word_valid) begin
        reply_version <= 1'b0;
        reply_slots   <= 1'b0;
        case (state)
          IDLE_HEADER: begin
            case (header)
              CMD_MOTOR_ENABLE: enable    <= rx_word[0];
              CMD_CLK_DIVISOR:  divisor   <= rx_word[7:0];
              // Bit 0 selects half stepping
              CMD_MICROSTEPS:   half_step <= rx_word[0];
              CMD_API_VERSION:  reply_version <= 1'b1;
              CMD_COORDINATED_STEP: begin
                reply_slots <= 1'b1;
                state       <= MOVE_DURATION;
              end
              default: begin
              end
            endcase
          end
          MOVE_DURATION:  state <= MOVE_INCREMENT;
          MOVE_INCREMENT: state <= MOVE_ACCEL;
          MOVE_ACCEL: begin
            state     <= IDLE_HEADER;
            // Full queue drops the move
            move_push <= (slots_free != '0);
          end
          default: state <= IDLE_HEADER;
        endcase
      end
    end
  end

  // Move words, direction from bit 0 of the header
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        IDLE_HEADER: begin
          if (header == CMD_COORDINATED_STEP) begin
            move_dir <= rx_word[0];
          end
        end
        MOVE_DURATION:  move_duration  <= count_t'(rx_word);
        MOVE_INCREMENT: move_increment <= count_t'(rx_word);
        MOVE_ACCEL:     move_accel     <= count_t'(rx_word);
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/spi_word.sv
`timescale 1ns/1ps
`default_nettype none

module spi_word
  import motion_pkg::*;
(
  input  wire        CLK,
  input  wire        reset,
  input  wire        SCK,
  input  wire        CS,
  input  wire        COPI,
  input  wire word_t tx_word,
  output logic       CIPO,
  output logic       word_valid,
  output word_t      rx_word
);

  // Two-flop synchronizers on every pin
  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_prev;
  // Reply load waits one cycle so the decoder has updated its select
  logic       load_reply;
  logic [5:0] bit_count;
  word_t      rx_shift;
  word_t      tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       selected;

  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign selected = ~cs_sync[1];
  // MSB first, valid before the first rising edge
  assign CIPO     = tx_shift[63];

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_sync   <= 2'b00;
      cs_sync    <= 2'b11;
      copi_sync  <= 2'b00;
      sck_prev   <= 1'b0;
      word_valid <= 1'b0;
      load_reply <= 1'b0;
      bit_count  <= '0;
      tx_shift   <= '0;
    end else begin
      sck_sync   <= {sck_sync[0], SCK};
      cs_sync    <= {cs_sync[0], CS};
      copi_sync  <= {copi_sync[0], COPI};
      sck_prev   <= sck_sync[1];
      word_valid <= 1'b0;
      load_reply <= word_valid;
      // Deselect restarts the word
      if (!selected) begin
        bit_count <= '0;
      end else if (sck_rise) begin
        // Counter wraps to 0 on the 64th bit
        bit_count <= bit_count + 1'b1;
        if (bit_count == 6'd63) begin
          word_valid <= 1'b1;
        end
      end
      // Skip the falling edge right after the last bit of a word
      if (load_reply) begin
        tx_shift <= tx_word;
      end else if (selected && sck_fall && (bit_count != '0)) begin
        tx_shift <= {tx_shift[62:0], 1'b0};
      end
    end
  end

  // Receive path
  always_ff @(posedge CLK) begin
    if (selected && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_sync[1]};
      if (bit_count == 6'd63) begin
        rx_word <= {rx_shift[62:0], copi_sync[1]};
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/motion_pkg.sv
`default_nettype none

package motion_pkg;

  // Host link word and its header byte
  typedef logic [63:0]        word_t;
  typedef logic [7:0]         header_t;
  // Encoder position and DDA accumulators
  typedef logic signed [63:0] count_t;
  typedef logic [7:0]         divisor_t;
  // Position in the eight-entry coil table
  typedef logic [2:0]         phase_t;
  // Queue index or free slot count, wide enough for MOVE_DEPTH itself
  typedef logic [2:0]         slot_t;

  // Command codes in bits 63:56 of a header word
  localparam header_t CMD_MOTOR_ENABLE     = 8'd1;
  localparam header_t CMD_CLK_DIVISOR      = 8'd2;
  localparam header_t CMD_MICROSTEPS       = 8'd3;
  localparam header_t CMD_API_VERSION      = 8'd4;
  localparam header_t CMD_COORDINATED_STEP = 8'd5;

  localparam int MOVE_DEPTH = 4;

  // Largest positive count minus 100 of headroom
  localparam count_t STEP_THRESHOLD = 64'sh7fff_ffff_ffff_ff9b;

  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  localparam divisor_t DEFAULT_DIVISOR = 8'd40;

  // Header first, then the three words of a move
  typedef enum logic [1:0] {
    IDLE_HEADER,
    MOVE_DURATION,
    MOVE_INCREMENT,
    MOVE_ACCEL
  } decoder_state_t;

endpackage

`default_nettype wire
